//--- rtl/i2s_defs.svh
`ifndef I2S_DEFS_SVH
`define I2S_DEFS_SVH

// Clock ratios

// System clocks per bit clock half period
`define I2S_BCLK_HALF 8

// System clocks per word clock half period, 32 bit slots per channel
`define I2S_LRCLK_HALF 512

// Data widths

// ADC sample width
`define I2S_SAMPLE_W 16

// DAC word width, as delivered by the hardware
`define I2S_WORD_W 32

// Slot numbering

// Received sample complete after this slot
`define I2S_LAST_RX_SLOT 16

`endif

//--- rtl/i2s_pkg.sv
package i2s_pkg;

  `include "i2s_defs.svh"

  // Meaningful widths
  typedef logic [`I2S_SAMPLE_W-1:0] sample_t;  // One ADC sample
  typedef logic [`I2S_WORD_W-1:0] dac_word_t;  // One hardware word for the DAC

  // Bit slot within a half-frame
  typedef logic [$clog2(`I2S_LRCLK_HALF / (2 * `I2S_BCLK_HALF))-1:0] slot_t;

  // Edge events from the clock generator
  typedef struct packed {
    logic bclk_rise;
    logic bclk_fall;
    logic lrclk_rise;
    logic lrclk_fall;
  } clk_edges_t;

  // Per-cycle commands to the data paths
  typedef struct packed {
    logic load;     // Take pending word at frame edge
    logic shift;    // Advance DAC bit
    logic sample;   // Take ADC bit
    logic publish;  // Present finished sample
  } slot_cmd_t;

  // Received sample with channel flag
  typedef struct packed {
    sample_t data;
    logic    right;
  } rx_sample_t;

  typedef enum logic [1:0] {IDLE, DELAY, DATA, TAIL} frame_state_e;

endpackage

//--- rtl/i2s_clock_gen.sv
`timescale 1ns/1ps
`include "i2s_defs.svh"

module i2s_clock_gen import i2s_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  output logic       mclk,   // Codec master clock, half system rate
  output logic       bclk,   // Bit clock
  output logic       lrclk,  // Word clock
  output clk_edges_t edges   // One-cycle edge strobes
);

  localparam int unsigned BCLK_CNT_W = $clog2(`I2S_BCLK_HALF);
  localparam int unsigned LRCLK_CNT_W = $clog2(`I2S_LRCLK_HALF);

  localparam logic [BCLK_CNT_W-1:0] BCLK_RELOAD = BCLK_CNT_W'(`I2S_BCLK_HALF - 1);
  localparam logic [LRCLK_CNT_W-1:0] LRCLK_RELOAD = LRCLK_CNT_W'(`I2S_LRCLK_HALF - 1);

  logic [BCLK_CNT_W-1:0] bclk_cnt_q;
  logic [LRCLK_CNT_W-1:0] lrclk_cnt_q;
  logic bclk_wrap;
  logic lrclk_wrap;

  assign bclk_wrap = (bclk_cnt_q == '0);    // Toggle point of the bit clock
  assign lrclk_wrap = (lrclk_cnt_q == '0);  // Toggle point of the word clock

  // Master clock, toggles every cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mclk <= 1'b0;
    end else begin
      mclk <= ~mclk;
    end
  end

  // Bit clock divider
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bclk_cnt_q <= BCLK_RELOAD;
      bclk       <= 1'b0;
    end else if (bclk_wrap) begin
      bclk_cnt_q <= BCLK_RELOAD;
      bclk       <= ~bclk;
    end else begin
      bclk_cnt_q <= bclk_cnt_q - 1'b1;
    end
  end

  // Word clock divider
  // First wrap 512 clocks after reset, lines up with a bit clock fall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lrclk_cnt_q <= LRCLK_RELOAD;
      lrclk       <= 1'b0;
    end else if (lrclk_wrap) begin
      lrclk_cnt_q <= LRCLK_RELOAD;
      lrclk       <= ~lrclk;
    end else begin
      lrclk_cnt_q <= lrclk_cnt_q - 1'b1;
    end
  end

  // Strobes mark the cycle in which the level is about to change
  always_comb begin
    edges.bclk_rise  = bclk_wrap & ~bclk;
    edges.bclk_fall  = bclk_wrap & bclk;
    edges.lrclk_rise = lrclk_wrap & ~lrclk;
    edges.lrclk_fall = lrclk_wrap & lrclk;
  end

endmodule

//--- rtl/i2s_frame_ctrl.sv
`timescale 1ns/1ps
`include "i2s_defs.svh"

module i2s_frame_ctrl import i2s_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  clk_edges_t edges,
  output slot_cmd_t  cmd     // Registered, one cycle per strobe
);

  localparam slot_t LAST_RX_SLOT = slot_t'(`I2S_LAST_RX_SLOT);
  localparam slot_t PUBLISH_SLOT = slot_t'(`I2S_LAST_RX_SLOT + 1);  // Rise after last bit

  frame_state_e state_q, state_d;
  slot_t        slot_q, slot_d;
  slot_cmd_t    cmd_d;
  logic         frame_edge;

  // Either word clock edge starts a half-frame
  assign frame_edge = edges.lrclk_rise | edges.lrclk_fall;

  always_comb begin
    state_d = state_q;
    slot_d  = slot_q;
    cmd_d   = '0;

    if (frame_edge) begin
      // Edge replaces the bit clock fall, so no shift here
      state_d    = DELAY;
      slot_d     = '0;
      cmd_d.load = 1'b1;
    end else begin
      case (state_q)
        IDLE: begin
          // Nothing until the first word clock edge
        end
        DELAY: begin
          if (edges.bclk_fall) begin  // Slot 0 done, MSB goes out
            cmd_d.shift = 1'b1;
            slot_d      = slot_q + 1'b1;
            state_d     = DATA;
          end
        end
        DATA: begin
          if (edges.bclk_fall) begin
            cmd_d.shift = 1'b1;
            slot_d      = slot_q + 1'b1;
            if (slot_q == LAST_RX_SLOT) begin
              state_d = TAIL;  // ADC bits all taken
            end
          end else if (edges.bclk_rise) begin
            cmd_d.sample = 1'b1;  // Slots 1 to 16
          end
        end
        TAIL: begin
          if (edges.bclk_fall) begin
            cmd_d.shift = 1'b1;
            slot_d      = slot_q + 1'b1;
          end else if (edges.bclk_rise && slot_q == PUBLISH_SLOT) begin
            cmd_d.publish = 1'b1;  // Once per half-frame
          end
        end
        default: begin
          state_d = IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      slot_q  <= '0;
      cmd     <= '0;
    end else begin
      state_q <= state_d;
      slot_q  <= slot_d;
      cmd     <= cmd_d;
    end
  end

endmodule

//--- rtl/i2s_tx_serializer.sv
`timescale 1ns/1ps
`include "i2s_defs.svh"

module i2s_tx_serializer import i2s_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  slot_cmd_t cmd,
  input  dac_word_t tx_word,   // Word from the hardware
  input  logic      tx_valid,  // Strobe with tx_word
  output logic      sdata      // DAC serial line
);

  dac_word_t                hold_q;     // Last offered word
  logic                     pending_q;  // Word waiting for next edge
  logic [`I2S_WORD_W:0]     shreg_q;    // Delay bit on top of the word

  // Holding register, latest offer wins
  always_ff @(posedge clk_i) begin
    if (tx_valid) begin
      hold_q <= tx_word;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (cmd.load) begin
      pending_q <= tx_valid;  // Offer in the load cycle counts for the next frame
    end else if (tx_valid) begin
      pending_q <= 1'b1;
    end
  end

  // Shift register, MSB first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shreg_q <= '0;
    end else if (cmd.load) begin
      // Leading zero covers the one-bit I2S delay
      if (pending_q) begin
        shreg_q <= {1'b0, hold_q};
      end else begin
        shreg_q <= '0;  // Silence
      end
    end else if (cmd.shift) begin
      shreg_q <= {shreg_q[`I2S_WORD_W-1:0], 1'b0};
    end
  end

  assign sdata = shreg_q[`I2S_WORD_W];

endmodule

//--- rtl/i2s_rx_deserializer.sv
`timescale 1ns/1ps

module i2s_rx_deserializer import i2s_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  slot_cmd_t  cmd,
  input  logic       sdata,      // ADC serial line
  input  logic       lrclk,      // Word clock level, high for right
  output rx_sample_t rx_sample,  // Held until next publish
  output logic       rx_valid    // One-cycle strobe
);

  sample_t shreg_q;

  // Shift in, MSB arrives first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shreg_q <= '0;
    end else if (cmd.load) begin
      shreg_q <= '0;  // Fresh half-frame
    end else if (cmd.sample) begin
      shreg_q <= {shreg_q[$bits(sample_t)-2:0], sdata};
    end
  end

  // Output sample
  always_ff @(posedge clk_i) begin
    if (cmd.publish) begin
      rx_sample.data  <= shreg_q;
      rx_sample.right <= lrclk;  // Still the level of this half-frame
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cmd.publish;
    end
  end

endmodule

//--- rtl/i2s_codec_if.sv
`timescale 1ns/1ps

module i2s_codec_if import i2s_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Codec pins
  output logic       ac_mclk,       // Master clock
  output logic       ac_bclk,       // Bit clock
  output logic       ac_lrclk,      // Word clock
  output logic       ac_dac_sdata,  // DAC serial data
  input  logic       ac_adc_sdata,  // ADC serial data

  // Hardware side, mono
  input  dac_word_t  tx_word,
  input  logic       tx_valid,
  output rx_sample_t rx_sample,
  output logic       rx_valid
);

  clk_edges_t edges;  // Clock edge events
  slot_cmd_t  cmd;    // Slot commands to both data paths

  // Clock and edge generation
  i2s_clock_gen i2s_clock_gen_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mclk   (ac_mclk),
    .bclk   (ac_bclk),
    .lrclk  (ac_lrclk),
    .edges  (edges)
  );

  // Slot sequencing
  i2s_frame_ctrl i2s_frame_ctrl_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .edges  (edges),
    .cmd    (cmd)
  );

  // DAC path
  i2s_tx_serializer i2s_tx_serializer_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cmd      (cmd),
    .tx_word  (tx_word),
    .tx_valid (tx_valid),
    .sdata    (ac_dac_sdata)
  );

  // ADC path, channel flag from the word clock pin level
  i2s_rx_deserializer i2s_rx_deserializer_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd       (cmd),
    .sdata     (ac_adc_sdata),
    .lrclk     (ac_lrclk),
    .rx_sample (rx_sample),
    .rx_valid  (rx_valid)
  );

endmodule

//--- tb/tb_i2s_codec_if.sv
`timescale 1ns/1ps
`include "i2s_defs.svh"

module tb_i2s_codec_if import i2s_pkg::*; ();

  localparam int NUM_ENTRIES = 10;
  localparam int HALF_FRAME = `I2S_LRCLK_HALF;         // Clocks per half-frame
  localparam int BCLK_PERIOD = 2 * `I2S_BCLK_HALF;
  localparam int LRCLK_PERIOD = 2 * `I2S_LRCLK_HALF;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * HALF_FRAME + 1024;
  localparam int FIRST_LEAD = 32;                      // Offer this far ahead of the edge
  localparam int SECOND_LEAD = 16;                     // Replacement offer
  localparam int VALID_WAIT = 2 * HALF_FRAME;          // Longest wait for one sample

  // One half-frame of stimulus with its expected result
  typedef struct packed {
    logic       offer;       // Word offered before the edge
    dac_word_t  word;
    logic       second;      // Second offer replaces the first
    dac_word_t  word2;
    rx_sample_t exp_sample;
  } entry_t;

  logic       clk_i;
  logic       rst_ni;
  logic       ac_mclk;
  logic       ac_bclk;
  logic       ac_lrclk;
  logic       ac_dac_sdata;
  logic       ac_adc_sdata;
  dac_word_t  tx_word;
  logic       tx_valid;
  rx_sample_t rx_sample;
  logic       rx_valid;

  entry_t      stim_table [NUM_ENTRIES];
  logic [31:0] lcg_state;
  int          cycle_count;  // Clocks since reset release
  int          error_count;
  int          test_count;
  int          fail_count;

  // Pin monitor state
  int   valid_count;
  int   mclk_misses;
  int   bclk_bad;
  int   bclk_periods;
  int   bclk_last;
  int   lrclk_bad;
  int   lrclk_periods;
  int   lrclk_last;
  logic mclk_prev;
  logic bclk_prev;
  logic lrclk_prev;

  assign ac_adc_sdata = ac_dac_sdata;  // Loopback DAC to ADC

  i2s_codec_if i2s_codec_if_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ac_mclk      (ac_mclk),
    .ac_bclk      (ac_bclk),
    .ac_lrclk     (ac_lrclk),
    .ac_dac_sdata (ac_dac_sdata),
    .ac_adc_sdata (ac_adc_sdata),
    .tx_word      (tx_word),
    .tx_valid     (tx_valid),
    .rx_sample    (rx_sample),
    .rx_valid     (rx_valid)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  // Watchdog
  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: run stopped after %0d clocks without finishing", cycle_count);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic dac_word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_sample(string name, rx_sample_t got, rx_sample_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got data=%h right=%h, expected data=%h right=%h",
               name, got.data, got.right, exp.data, exp.right);
      error_count++;
    end
  endtask

  task automatic check_level(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic end_test(string name, int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("PASS  %s", name);
    end else begin
      fail_count++;
      $display("FAIL  %s, %0d errors", name, error_count - errs_before);
    end
  endtask

  // Corner words first, random words elsewhere
  task automatic build_table();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      stim_table[i].offer  = 1'b1;
      stim_table[i].word   = lcg_next();
      stim_table[i].second = 1'b0;
      stim_table[i].word2  = '0;
    end
    stim_table[0].word   = 32'hFFFF_FFFF;  // All ones
    stim_table[1].word   = 32'hAAAA_AAAA;  // Alternating bits
    stim_table[2].offer  = 1'b0;           // Silence
    stim_table[3].word   = 32'h5555_5555;
    stim_table[5].second = 1'b1;
    stim_table[5].word2  = lcg_next();
    stim_table[7].offer  = 1'b0;
    stim_table[8].second = 1'b1;
    stim_table[8].word2  = 32'h0001_FFFE;
    stim_table[9].word   = 32'h8000_0001;  // Only the MSB reaches the sample
    // Expected data is the upper half of the last offered word
    // Right channel on even half-frames
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!stim_table[i].offer) begin
        stim_table[i].exp_sample.data = '0;
      end else if (stim_table[i].second) begin
        stim_table[i].exp_sample.data = stim_table[i].word2[`I2S_WORD_W-1 -: `I2S_SAMPLE_W];
      end else begin
        stim_table[i].exp_sample.data = stim_table[i].word[`I2S_WORD_W-1 -: `I2S_SAMPLE_W];
      end
      stim_table[i].exp_sample.right = (i % 2 == 0);
    end
  endtask

  task automatic wait_for_cycle(int target);
    while (cycle_count < target) begin
      @(negedge clk_i);
    end
  endtask

  // One-cycle strobe driven from a falling edge
  task automatic offer_word(dac_word_t word);
    tx_word  = word;
    tx_valid = 1'b1;
    @(negedge clk_i);
    tx_valid = 1'b0;
  endtask

  task automatic await_sample(output logic found);
    int waited;
    found  = 1'b0;
    waited = 0;
    while (!found && waited < VALID_WAIT) begin
      @(negedge clk_i);
      if (rx_valid) begin
        found = 1'b1;
      end
      waited++;
    end
  endtask

  // Periods counted at the pins, from the first clock after release
  always @(negedge clk_i) begin
    if (rst_ni && cycle_count > 0) begin
      if (ac_mclk == mclk_prev) begin
        mclk_misses++;
      end
      if (ac_bclk && !bclk_prev) begin
        if (bclk_last >= 0) begin
          bclk_periods++;
          if (cycle_count - bclk_last != BCLK_PERIOD) begin
            bclk_bad++;
          end
        end
        bclk_last = cycle_count;
      end
      if (ac_lrclk && !lrclk_prev) begin
        if (lrclk_last >= 0) begin
          lrclk_periods++;
          if (cycle_count - lrclk_last != LRCLK_PERIOD) begin
            lrclk_bad++;
          end
        end
        lrclk_last = cycle_count;
      end
      if (rx_valid) begin
        valid_count++;  // A long pulse counts once per high cycle
      end
    end
    mclk_prev  = ac_mclk;
    bclk_prev  = ac_bclk;
    lrclk_prev = ac_lrclk;
  end

  // Quiet lines until the first word clock edge
  always @(negedge clk_i) begin
    if (rst_ni && cycle_count < HALF_FRAME) begin
      check_level("ac_lrclk before first edge", ac_lrclk, 1'b0);
      check_level("ac_dac_sdata before first edge", ac_dac_sdata, 1'b0);
      check_level("rx_valid before first edge", rx_valid, 1'b0);
    end
    if (rst_ni && cycle_count < `I2S_BCLK_HALF) begin
      check_level("ac_bclk before first edge", ac_bclk, 1'b0);  // First rise after one half period
    end
  end

  initial begin
    logic found;
    int   errs_before;
    int   idle_errs;
    int   target;
    rst_ni        = 1'b0;
    tx_word       = '0;
    tx_valid      = 1'b0;
    lcg_state     = 32'd78;
    error_count   = 0;
    test_count    = 0;
    fail_count    = 0;
    valid_count   = 0;
    mclk_misses   = 0;
    bclk_bad      = 0;
    bclk_periods  = 0;
    bclk_last     = -1;
    lrclk_bad     = 0;
    lrclk_periods = 0;
    lrclk_last    = -1;
    mclk_prev     = 1'b0;
    bclk_prev     = 1'b0;
    lrclk_prev    = 1'b0;
    build_table();

    errs_before = error_count;
    repeat (3) @(negedge clk_i);
    check_level("ac_mclk in reset", ac_mclk, 1'b0);
    check_level("ac_bclk in reset", ac_bclk, 1'b0);
    check_level("ac_lrclk in reset", ac_lrclk, 1'b0);
    check_level("ac_dac_sdata in reset", ac_dac_sdata, 1'b0);
    check_level("rx_valid in reset", rx_valid, 1'b0);
    end_test("levels in reset", errs_before);
    rst_ni    = 1'b1;
    idle_errs = error_count;

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      target = (i + 1) * HALF_FRAME;  // Word clock edge of this half-frame
      if (stim_table[i].offer) begin
        wait_for_cycle(target - FIRST_LEAD);
        offer_word(stim_table[i].word);
        if (stim_table[i].second) begin
          wait_for_cycle(target - SECOND_LEAD);
          offer_word(stim_table[i].word2);
        end
      end
      if (i == 0) begin
        wait_for_cycle(target);
        end_test("idle levels until first edge", idle_errs);
      end
      errs_before = error_count;
      await_sample(found);
      if (!found) begin
        $display("Half-frame %0d published no sample within %0d clocks", i, VALID_WAIT);
        error_count++;
      end else begin
        check_sample($sformatf("rx_sample half-frame %0d", i), rx_sample,
                     stim_table[i].exp_sample);
      end
      end_test($sformatf("half-frame %0d", i), errs_before);
    end

    repeat (2) @(negedge clk_i);  // Monitors catch up with the last pulse
    errs_before = error_count;
    check_count("rx_valid high cycles", valid_count, NUM_ENTRIES);
    end_test("one rx_valid per half-frame", errs_before);

    errs_before = error_count;
    check_count("ac_mclk missed toggles", mclk_misses, 0);
    check_count("ac_bclk wrong periods", bclk_bad, 0);
    check_level("ac_bclk period seen", bclk_periods > 0, 1'b1);
    check_count("ac_lrclk wrong periods", lrclk_bad, 0);
    check_level("ac_lrclk period seen", lrclk_periods > 0, 1'b1);
    end_test("clock periods at pins", errs_before);

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             test_count, test_count - fail_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+rtl
rtl/i2s_pkg.sv
rtl/i2s_clock_gen.sv
rtl/i2s_frame_ctrl.sv
rtl/i2s_tx_serializer.sv
rtl/i2s_rx_deserializer.sv
rtl/i2s_codec_if.sv
tb/tb_i2s_codec_if.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_i2s_codec_if
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: sim clean

# Build and run, pass only if the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
